// File: source/exec_pkg.sv
package exec_pkg;

    localparam int XLEN = 32;                   // Data word width

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [2*XLEN-1:0] dword_t;         // Multiplier addend or product
    typedef logic [4:0]        reg_addr_t;
    typedef logic [3:0]        alu_op_t;

    // ALU operation codes
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLT  = 4'd2;
    localparam alu_op_t ALU_SLTU = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_OR   = 4'd5;
    localparam alu_op_t ALU_XOR  = 4'd6;
    localparam alu_op_t ALU_NOR  = 4'd7;
    localparam alu_op_t ALU_SLL  = 4'd8;
    localparam alu_op_t ALU_SRL  = 4'd9;
    localparam alu_op_t ALU_SRA  = 4'd10;
    localparam alu_op_t ALU_LUI  = 4'd11;       // Second operand passes through

    typedef logic src1_sel_t;
    localparam src1_sel_t SRC1_REG = 1'b0;
    localparam src1_sel_t SRC1_PC  = 1'b1;

    typedef logic src2_sel_t;
    localparam src2_sel_t SRC2_REG = 1'b0;
    localparam src2_sel_t SRC2_IMM = 1'b1;

    // One-hot lane B write-back select
    typedef logic [2:0] wb_sel_t;
    localparam wb_sel_t WB_SEL_ALU    = 3'b001;
    localparam wb_sel_t WB_SEL_MUL_LO = 3'b010; // Product bits 31..0
    localparam wb_sel_t WB_SEL_MUL_HI = 3'b100; // Product bits 63..32

    localparam reg_addr_t ZERO_REG = 5'd0;      // Never forwarded

endpackage

// File: source/operand_forward.sv
`timescale 1ns/1ns

module operand_forward (
    input  exec_pkg::word_t     ex_rdata,
    input  exec_pkg::reg_addr_t ex_raddr,
    input  logic                mem_we_a,
    input  logic                mem_we_b,
    input  exec_pkg::reg_addr_t mem_waddr_a,
    input  exec_pkg::reg_addr_t mem_waddr_b,
    input  exec_pkg::word_t     mem_wdata_a,
    input  exec_pkg::word_t     mem_wdata_b,
    input  logic                wb_we_a,
    input  logic                wb_we_b,
    input  exec_pkg::reg_addr_t wb_waddr_a,
    input  exec_pkg::reg_addr_t wb_waddr_b,
    input  exec_pkg::word_t     wb_wdata_a,
    input  exec_pkg::word_t     wb_wdata_b,
    output exec_pkg::word_t     fwd_rdata
);

    logic not_zero;
    logic hit_mem_a, hit_mem_b, hit_wb_a, hit_wb_b;

    assign not_zero  = (ex_raddr != exec_pkg::ZERO_REG);
    assign hit_mem_a = not_zero & mem_we_a & (mem_waddr_a == ex_raddr);
    assign hit_mem_b = not_zero & mem_we_b & (mem_waddr_b == ex_raddr);
    assign hit_wb_a  = not_zero & wb_we_a  & (wb_waddr_a  == ex_raddr);
    assign hit_wb_b  = not_zero & wb_we_b  & (wb_waddr_b  == ex_raddr);

    // MEM beats WB and lane B beats lane A
    always_comb begin
        if (hit_mem_b)      fwd_rdata = mem_wdata_b;
        else if (hit_mem_a) fwd_rdata = mem_wdata_a;
        else if (hit_wb_b)  fwd_rdata = wb_wdata_b;
        else if (hit_wb_a)  fwd_rdata = wb_wdata_a;
        else                fwd_rdata = ex_rdata;   // Register file value
    end

endmodule

// File: source/lane_alu.sv
`timescale 1ns/1ns

module lane_alu (
    input  exec_pkg::word_t     pc,
    input  exec_pkg::word_t     imm,
    input  exec_pkg::word_t     rdata1,
    input  exec_pkg::word_t     rdata2,
    input  exec_pkg::src1_sel_t src1_sel,
    input  exec_pkg::src2_sel_t src2_sel,
    input  exec_pkg::alu_op_t   alu_op,
    output exec_pkg::word_t     result
);

    exec_pkg::word_t op1;
    exec_pkg::word_t op2;
    exec_pkg::word_t sum;
    exec_pkg::word_t diff;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    assign op1 = (src1_sel == exec_pkg::SRC1_PC)  ? pc  : rdata1;
    assign op2 = (src2_sel == exec_pkg::SRC2_IMM) ? imm : rdata2;

    assign sum   = op1 + op2;
    assign diff  = op1 - op2;
    assign shamt = op2[4:0];                    // Low 5 bits only

    assign lt_signed   = ($signed(op1) < $signed(op2));
    assign lt_unsigned = (op1 < op2);

    always_comb begin
        case (alu_op)
            exec_pkg::ALU_ADD:  result = sum;
            exec_pkg::ALU_SUB:  result = diff;
            exec_pkg::ALU_SLT:  result = {{(exec_pkg::XLEN-1){1'b0}}, lt_signed};
            exec_pkg::ALU_SLTU: result = {{(exec_pkg::XLEN-1){1'b0}}, lt_unsigned};
            exec_pkg::ALU_AND:  result = op1 & op2;
            exec_pkg::ALU_OR:   result = op1 | op2;
            exec_pkg::ALU_XOR:  result = op1 ^ op2;
            exec_pkg::ALU_NOR:  result = ~(op1 | op2);
            exec_pkg::ALU_SLL:  result = op1 << shamt;
            exec_pkg::ALU_SRL:  result = op1 >> shamt;
            exec_pkg::ALU_SRA:  result = exec_pkg::word_t'($signed(op1) >>> shamt);
            exec_pkg::ALU_LUI:  result = op2;     // Upper immediate comes pre-shifted
            default:            result = '0;
        endcase
    end

endmodule

// File: source/mul_partial.sv
`timescale 1ns/1ns

module mul_partial (
    input  exec_pkg::word_t  mul_x,
    input  exec_pkg::word_t  mul_y,
    input  logic             mul_signed,
    output exec_pkg::dword_t addend_lo,
    output exec_pkg::dword_t addend_hi
);

    exec_pkg::dword_t x_ext;
    exec_pkg::dword_t y_ext;
    exec_pkg::dword_t y_lo;
    exec_pkg::dword_t y_hi;
    logic             x_fill;
    logic             y_fill;

    assign x_fill = mul_signed & mul_x[exec_pkg::XLEN-1];
    assign y_fill = mul_signed & mul_y[exec_pkg::XLEN-1];

    assign x_ext = {{exec_pkg::XLEN{x_fill}}, mul_x};
    assign y_ext = {{exec_pkg::XLEN{y_fill}}, mul_y};

    // Split y at bit 16 with the low part always unsigned
    assign y_lo = {48'd0, y_ext[15:0]};
    assign y_hi = {16'd0, y_ext[63:16]};

    // Both products wrap modulo 2^64 so their sum is the exact product
    assign addend_lo = x_ext * y_lo;
    assign addend_hi = (x_ext * y_hi) << 16;

endmodule

// File: source/wb_select.sv
`timescale 1ns/1ns

module wb_select (
    input  exec_pkg::word_t  alu_result,
    input  exec_pkg::dword_t addend_lo,
    input  exec_pkg::dword_t addend_hi,
    input  exec_pkg::wb_sel_t wb_sel,
    output exec_pkg::word_t  wdata
);

    exec_pkg::dword_t product;

    assign product = addend_lo + addend_hi;    // Second multiply stage

    // AND-OR mux on the one-hot select
    assign wdata = ({exec_pkg::XLEN{wb_sel[0]}} & alu_result)
                 | ({exec_pkg::XLEN{wb_sel[1]}} & product[exec_pkg::XLEN-1:0])
                 | ({exec_pkg::XLEN{wb_sel[2]}} & product[2*exec_pkg::XLEN-1:exec_pkg::XLEN]);

endmodule

// File: source/stage_regs.sv
`timescale 1ns/1ns

module stage_regs (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ex_valid_a,
    input  logic                ex_valid_b,
    input  logic                ex_rf_we_a,
    input  logic                ex_rf_we_b,
    input  exec_pkg::reg_addr_t ex_waddr_a,
    input  exec_pkg::reg_addr_t ex_waddr_b,
    input  exec_pkg::word_t     ex_result_a,
    input  exec_pkg::word_t     ex_result_b,
    input  exec_pkg::dword_t    ex_addend_lo,
    input  exec_pkg::dword_t    ex_addend_hi,
    input  exec_pkg::wb_sel_t   ex_wb_sel_b,
    input  exec_pkg::word_t     mem_wdata_b,
    output logic                mem_we_a,
    output logic                mem_we_b,
    output exec_pkg::reg_addr_t mem_waddr_a,
    output exec_pkg::reg_addr_t mem_waddr_b,
    output exec_pkg::word_t     mem_result_a,
    output exec_pkg::word_t     mem_result_b,
    output exec_pkg::dword_t    mem_addend_lo,
    output exec_pkg::dword_t    mem_addend_hi,
    output exec_pkg::wb_sel_t   mem_wb_sel_b,
    output logic                wb_we_a,
    output logic                wb_we_b,
    output exec_pkg::reg_addr_t wb_waddr_a,
    output exec_pkg::reg_addr_t wb_waddr_b,
    output exec_pkg::word_t     wb_wdata_a,
    output exec_pkg::word_t     wb_wdata_b
);

    // Write enables are cleared for a bubble lane
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_we_a <= 1'b0;
            mem_we_b <= 1'b0;
            wb_we_a  <= 1'b0;
            wb_we_b  <= 1'b0;
        end else begin
            mem_we_a <= ex_rf_we_a & ex_valid_a;
            mem_we_b <= ex_rf_we_b & ex_valid_b;
            wb_we_a  <= mem_we_a;
            wb_we_b  <= mem_we_b;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        mem_waddr_a   <= ex_waddr_a;
        mem_waddr_b   <= ex_waddr_b;
        mem_result_a  <= ex_result_a;
        mem_result_b  <= ex_result_b;
        mem_addend_lo <= ex_addend_lo;
        mem_addend_hi <= ex_addend_hi;
        mem_wb_sel_b  <= ex_wb_sel_b;
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        wb_waddr_a <= mem_waddr_a;
        wb_waddr_b <= mem_waddr_b;
        wb_wdata_a <= mem_result_a;             // Lane A is ALU only
        wb_wdata_b <= mem_wdata_b;              // Selected in MEM
    end

endmodule

// File: source/ex_mem_wb.sv
`timescale 1ns/1ns

module ex_mem_wb (
    input  logic                clk,
    input  logic                arst_n,
    // Lane A issue
    input  logic                issue_valid_a,
    input  exec_pkg::word_t     pc_a,
    input  exec_pkg::word_t     imm_a,
    input  exec_pkg::word_t     rdata1_a,
    input  exec_pkg::word_t     rdata2_a,
    input  exec_pkg::reg_addr_t raddr1_a,
    input  exec_pkg::reg_addr_t raddr2_a,
    input  exec_pkg::src1_sel_t src1_sel_a,
    input  exec_pkg::src2_sel_t src2_sel_a,
    input  exec_pkg::alu_op_t   alu_op_a,
    input  logic                rf_we_a,
    input  exec_pkg::reg_addr_t rf_waddr_a,
    // Lane B issue holds the younger instruction
    input  logic                issue_valid_b,
    input  exec_pkg::word_t     pc_b,
    input  exec_pkg::word_t     imm_b,
    input  exec_pkg::word_t     rdata1_b,
    input  exec_pkg::word_t     rdata2_b,
    input  exec_pkg::reg_addr_t raddr1_b,
    input  exec_pkg::reg_addr_t raddr2_b,
    input  exec_pkg::src1_sel_t src1_sel_b,
    input  exec_pkg::src2_sel_t src2_sel_b,
    input  exec_pkg::alu_op_t   alu_op_b,
    input  logic                rf_we_b,
    input  exec_pkg::reg_addr_t rf_waddr_b,
    input  exec_pkg::wb_sel_t   wb_sel_b,
    input  logic                mul_signed,
    // Register file write ports
    output logic                wb_rf_we_a,
    output logic                wb_rf_we_b,
    output exec_pkg::reg_addr_t wb_rf_waddr_a,
    output exec_pkg::reg_addr_t wb_rf_waddr_b,
    output exec_pkg::word_t     wb_rf_wdata_a,
    output exec_pkg::word_t     wb_rf_wdata_b
);

    exec_pkg::word_t     fwd1_a, fwd2_a;        // Forwarded operands
    exec_pkg::word_t     fwd1_b, fwd2_b;
    exec_pkg::word_t     ex_result_a, ex_result_b;
    exec_pkg::dword_t    ex_addend_lo, ex_addend_hi;

    logic                mem_we_a, mem_we_b;
    exec_pkg::reg_addr_t mem_waddr_a, mem_waddr_b;
    exec_pkg::word_t     mem_result_a, mem_result_b;
    exec_pkg::dword_t    mem_addend_lo, mem_addend_hi;
    exec_pkg::wb_sel_t   mem_wb_sel_b;
    exec_pkg::word_t     mem_wdata_b;           // Lane B data as written back

    operand_forward u_fwd1_a (
        .ex_rdata    (rdata1_a),      .ex_raddr    (raddr1_a),
        .mem_we_a    (mem_we_a),      .mem_we_b    (mem_we_b),
        .mem_waddr_a (mem_waddr_a),   .mem_waddr_b (mem_waddr_b),
        .mem_wdata_a (mem_result_a),  .mem_wdata_b (mem_wdata_b),
        .wb_we_a     (wb_rf_we_a),    .wb_we_b     (wb_rf_we_b),
        .wb_waddr_a  (wb_rf_waddr_a), .wb_waddr_b  (wb_rf_waddr_b),
        .wb_wdata_a  (wb_rf_wdata_a), .wb_wdata_b  (wb_rf_wdata_b),
        .fwd_rdata   (fwd1_a)
    );

    operand_forward u_fwd2_a (
        .ex_rdata    (rdata2_a),      .ex_raddr    (raddr2_a),
        .mem_we_a    (mem_we_a),      .mem_we_b    (mem_we_b),
        .mem_waddr_a (mem_waddr_a),   .mem_waddr_b (mem_waddr_b),
        .mem_wdata_a (mem_result_a),  .mem_wdata_b (mem_wdata_b),
        .wb_we_a     (wb_rf_we_a),    .wb_we_b     (wb_rf_we_b),
        .wb_waddr_a  (wb_rf_waddr_a), .wb_waddr_b  (wb_rf_waddr_b),
        .wb_wdata_a  (wb_rf_wdata_a), .wb_wdata_b  (wb_rf_wdata_b),
        .fwd_rdata   (fwd2_a)
    );

    operand_forward u_fwd1_b (
        .ex_rdata    (rdata1_b),      .ex_raddr    (raddr1_b),
        .mem_we_a    (mem_we_a),      .mem_we_b    (mem_we_b),
        .mem_waddr_a (mem_waddr_a),   .mem_waddr_b (mem_waddr_b),
        .mem_wdata_a (mem_result_a),  .mem_wdata_b (mem_wdata_b),
        .wb_we_a     (wb_rf_we_a),    .wb_we_b     (wb_rf_we_b),
        .wb_waddr_a  (wb_rf_waddr_a), .wb_waddr_b  (wb_rf_waddr_b),
        .wb_wdata_a  (wb_rf_wdata_a), .wb_wdata_b  (wb_rf_wdata_b),
        .fwd_rdata   (fwd1_b)
    );

    operand_forward u_fwd2_b (
        .ex_rdata    (rdata2_b),      .ex_raddr    (raddr2_b),
        .mem_we_a    (mem_we_a),      .mem_we_b    (mem_we_b),
        .mem_waddr_a (mem_waddr_a),   .mem_waddr_b (mem_waddr_b),
        .mem_wdata_a (mem_result_a),  .mem_wdata_b (mem_wdata_b),
        .wb_we_a     (wb_rf_we_a),    .wb_we_b     (wb_rf_we_b),
        .wb_waddr_a  (wb_rf_waddr_a), .wb_waddr_b  (wb_rf_waddr_b),
        .wb_wdata_a  (wb_rf_wdata_a), .wb_wdata_b  (wb_rf_wdata_b),
        .fwd_rdata   (fwd2_b)
    );

    lane_alu u_alu_a (
        .pc       (pc_a),
        .imm      (imm_a),
        .rdata1   (fwd1_a),
        .rdata2   (fwd2_a),
        .src1_sel (src1_sel_a),
        .src2_sel (src2_sel_a),
        .alu_op   (alu_op_a),
        .result   (ex_result_a)
    );

    lane_alu u_alu_b (
        .pc       (pc_b),
        .imm      (imm_b),
        .rdata1   (fwd1_b),
        .rdata2   (fwd2_b),
        .src1_sel (src1_sel_b),
        .src2_sel (src2_sel_b),
        .alu_op   (alu_op_b),
        .result   (ex_result_b)
    );

    // Multiply always takes the forwarded register operands
    mul_partial u_mul (
        .mul_x      (fwd1_b),
        .mul_y      (fwd2_b),
        .mul_signed (mul_signed),
        .addend_lo  (ex_addend_lo),
        .addend_hi  (ex_addend_hi)
    );

    wb_select u_wb_sel (
        .alu_result (mem_result_b),
        .addend_lo  (mem_addend_lo),
        .addend_hi  (mem_addend_hi),
        .wb_sel     (mem_wb_sel_b),
        .wdata      (mem_wdata_b)
    );

    stage_regs u_regs (
        .clk           (clk),
        .arst_n        (arst_n),
        .ex_valid_a    (issue_valid_a),
        .ex_valid_b    (issue_valid_b),
        .ex_rf_we_a    (rf_we_a),
        .ex_rf_we_b    (rf_we_b),
        .ex_waddr_a    (rf_waddr_a),
        .ex_waddr_b    (rf_waddr_b),
        .ex_result_a   (ex_result_a),
        .ex_result_b   (ex_result_b),
        .ex_addend_lo  (ex_addend_lo),
        .ex_addend_hi  (ex_addend_hi),
        .ex_wb_sel_b   (wb_sel_b),
        .mem_wdata_b   (mem_wdata_b),
        .mem_we_a      (mem_we_a),
        .mem_we_b      (mem_we_b),
        .mem_waddr_a   (mem_waddr_a),
        .mem_waddr_b   (mem_waddr_b),
        .mem_result_a  (mem_result_a),
        .mem_result_b  (mem_result_b),
        .mem_addend_lo (mem_addend_lo),
        .mem_addend_hi (mem_addend_hi),
        .mem_wb_sel_b  (mem_wb_sel_b),
        .wb_we_a       (wb_rf_we_a),
        .wb_we_b       (wb_rf_we_b),
        .wb_waddr_a    (wb_rf_waddr_a),
        .wb_waddr_b    (wb_rf_waddr_b),
        .wb_wdata_a    (wb_rf_wdata_a),
        .wb_wdata_b    (wb_rf_wdata_b)
    );

endmodule

// File: test/tb_ex_mem_wb.sv
`timescale 1ns/1ns

module tb_ex_mem_wb;

    localparam int MAX_VEC     = 64;
    localparam int MIN_VEC     = 20;            // Lines the vector file must supply
    localparam int NUM_FIELDS  = 32;
    localparam int MAX_CYCLES  = 400;
    localparam int LANE_A      = 0;             // Field offsets within a line
    localparam int LANE_B      = 12;
    localparam int EXP         = 26;

    logic                clk;
    logic                arst_n;
    logic                issue_valid_a, issue_valid_b;
    exec_pkg::word_t     pc_a, imm_a, rdata1_a, rdata2_a;
    exec_pkg::word_t     pc_b, imm_b, rdata1_b, rdata2_b;
    exec_pkg::reg_addr_t raddr1_a, raddr2_a, rf_waddr_a;
    exec_pkg::reg_addr_t raddr1_b, raddr2_b, rf_waddr_b;
    exec_pkg::src1_sel_t src1_sel_a, src1_sel_b;
    exec_pkg::src2_sel_t src2_sel_a, src2_sel_b;
    exec_pkg::alu_op_t   alu_op_a, alu_op_b;
    logic                rf_we_a, rf_we_b;
    exec_pkg::wb_sel_t   wb_sel_b;
    logic                mul_signed;
    logic                wb_rf_we_a, wb_rf_we_b;
    exec_pkg::reg_addr_t wb_rf_waddr_a, wb_rf_waddr_b;
    exec_pkg::word_t     wb_rf_wdata_a, wb_rf_wdata_b;

    logic [31:0] vec_mem [0:MAX_VEC-1][0:NUM_FIELDS-1];
    int          num_vec;
    int          error_count;
    int          check_count;
    logic        load_ok;
    logic [31:0] seed_word;

    ex_mem_wb uut (.*);

    always #20 clk = ~clk;

    initial begin : watchdog
        int cyc;
        for (cyc = 0; cyc < MAX_CYCLES; cyc++) begin
            @(posedge clk);
        end
        $display("ERROR: simulation did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        int    lines;
        string text;
        fd = $fopen("test/ex_mem_wb_vectors.txt", "r");
        num_vec = 0;
        load_ok = 1'b0;
        if (fd == 0) begin
            $display("ERROR: could not open the vector file");
            error_count++;
        end else begin
            for (lines = 0; lines < 4 * MAX_VEC && !$feof(fd) && num_vec < MAX_VEC;
                 lines++) begin
                text = "";
                n = $fgets(text, fd);
                if (n > 1 && text.getc(0) != "#") begin  // Skip blanks and comments
                    n = $sscanf(text,
                        "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                        vec_mem[num_vec][0],  vec_mem[num_vec][1],  vec_mem[num_vec][2],
                        vec_mem[num_vec][3],  vec_mem[num_vec][4],  vec_mem[num_vec][5],
                        vec_mem[num_vec][6],  vec_mem[num_vec][7],  vec_mem[num_vec][8],
                        vec_mem[num_vec][9],  vec_mem[num_vec][10], vec_mem[num_vec][11],
                        vec_mem[num_vec][12], vec_mem[num_vec][13], vec_mem[num_vec][14],
                        vec_mem[num_vec][15], vec_mem[num_vec][16], vec_mem[num_vec][17],
                        vec_mem[num_vec][18], vec_mem[num_vec][19], vec_mem[num_vec][20],
                        vec_mem[num_vec][21], vec_mem[num_vec][22], vec_mem[num_vec][23],
                        vec_mem[num_vec][24], vec_mem[num_vec][25], vec_mem[num_vec][26],
                        vec_mem[num_vec][27], vec_mem[num_vec][28], vec_mem[num_vec][29],
                        vec_mem[num_vec][30], vec_mem[num_vec][31]);
                    if (n == NUM_FIELDS) begin
                        num_vec++;
                    end else begin
                        $display("ERROR: vector line %0d has %0d fields", num_vec, n);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
            if (num_vec < MIN_VEC) begin
                $display("ERROR: vector file ended after %0d lines, at least %0d needed",
                         num_vec, MIN_VEC);
                error_count++;
            end else begin
                load_ok = 1'b1;
            end
        end
    endtask

    // Register 0 operands that the lane ignores get random data
    function automatic logic [31:0] operand_data(input logic [31:0] rdata,
                                                 input logic [31:0] raddr,
                                                 input logic unused);
        if (raddr == 0 && unused)
            return $urandom;
        return rdata;
    endfunction

    task automatic drive_line(input int k);
        logic alu_b;
        alu_b = (vec_mem[k][LANE_B+12][2:0] == exec_pkg::WB_SEL_ALU);
        issue_valid_a <= vec_mem[k][LANE_A+0][0];
        pc_a          <= vec_mem[k][LANE_A+1];
        imm_a         <= vec_mem[k][LANE_A+2];
        rdata1_a      <= operand_data(vec_mem[k][LANE_A+3], vec_mem[k][LANE_A+5],
                                      vec_mem[k][LANE_A+7][0] == exec_pkg::SRC1_PC);
        rdata2_a      <= operand_data(vec_mem[k][LANE_A+4], vec_mem[k][LANE_A+6],
                                      vec_mem[k][LANE_A+8][0] == exec_pkg::SRC2_IMM);
        raddr1_a      <= vec_mem[k][LANE_A+5][4:0];
        raddr2_a      <= vec_mem[k][LANE_A+6][4:0];
        src1_sel_a    <= vec_mem[k][LANE_A+7][0];
        src2_sel_a    <= vec_mem[k][LANE_A+8][0];
        alu_op_a      <= vec_mem[k][LANE_A+9][3:0];
        rf_we_a       <= vec_mem[k][LANE_A+10][0];
        rf_waddr_a    <= vec_mem[k][LANE_A+11][4:0];
        issue_valid_b <= vec_mem[k][LANE_B+0][0];
        pc_b          <= vec_mem[k][LANE_B+1];
        imm_b         <= vec_mem[k][LANE_B+2];
        rdata1_b      <= operand_data(vec_mem[k][LANE_B+3], vec_mem[k][LANE_B+5],
                                      vec_mem[k][LANE_B+7][0] == exec_pkg::SRC1_PC && alu_b);
        rdata2_b      <= operand_data(vec_mem[k][LANE_B+4], vec_mem[k][LANE_B+6],
                                      vec_mem[k][LANE_B+8][0] == exec_pkg::SRC2_IMM && alu_b);
        raddr1_b      <= vec_mem[k][LANE_B+5][4:0];
        raddr2_b      <= vec_mem[k][LANE_B+6][4:0];
        src1_sel_b    <= vec_mem[k][LANE_B+7][0];
        src2_sel_b    <= vec_mem[k][LANE_B+8][0];
        alu_op_b      <= vec_mem[k][LANE_B+9][3:0];
        rf_we_b       <= vec_mem[k][LANE_B+10][0];
        rf_waddr_b    <= vec_mem[k][LANE_B+11][4:0];
        wb_sel_b      <= vec_mem[k][LANE_B+12][2:0];
        mul_signed    <= vec_mem[k][LANE_B+13][0];
    endtask

    task automatic drive_bubble();
        issue_valid_a <= 1'b0;
        issue_valid_b <= 1'b0;
        rf_we_a       <= 1'b0;
        rf_we_b       <= 1'b0;
    endtask

    task automatic check_wb(input int k);
        string tag;
        tag = $sformatf("line %0d", k);
        check_value(wb_rf_we_a, vec_mem[k][EXP+0], {tag, " we_a"});
        if (vec_mem[k][EXP+0][0]) begin        // Address and data only matter on a write
            check_value(wb_rf_waddr_a, vec_mem[k][EXP+1], {tag, " waddr_a"});
            check_value(wb_rf_wdata_a, vec_mem[k][EXP+2], {tag, " wdata_a"});
        end
        check_value(wb_rf_we_b, vec_mem[k][EXP+3], {tag, " we_b"});
        if (vec_mem[k][EXP+3][0]) begin
            check_value(wb_rf_waddr_b, vec_mem[k][EXP+4], {tag, " waddr_b"});
            check_value(wb_rf_wdata_b, vec_mem[k][EXP+5], {tag, " wdata_b"});
        end
    endtask

    initial begin : main
        int j;
        clk = 1'b0;
        arst_n = 1'b0;
        issue_valid_a = 1'b0;
        issue_valid_b = 1'b0;
        pc_a = '0;
        imm_a = '0;
        rdata1_a = '0;
        rdata2_a = '0;
        pc_b = '0;
        imm_b = '0;
        rdata1_b = '0;
        rdata2_b = '0;
        raddr1_a = '0;
        raddr2_a = '0;
        rf_waddr_a = '0;
        raddr1_b = '0;
        raddr2_b = '0;
        rf_waddr_b = '0;
        src1_sel_a = '0;
        src2_sel_a = '0;
        src1_sel_b = '0;
        src2_sel_b = '0;
        alu_op_a = '0;
        alu_op_b = '0;
        rf_we_a = 1'b0;
        rf_we_b = 1'b0;
        wb_sel_b = exec_pkg::WB_SEL_ALU;
        mul_signed = 1'b0;
        error_count = 0;
        check_count = 0;
        seed_word = $urandom(19461);
        load_vectors();
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_value(wb_rf_we_a, 0, "we_a in reset");
        check_value(wb_rf_we_b, 0, "we_b in reset");
        @(posedge clk);
        arst_n <= 1'b1;
        if (load_ok) begin
            for (j = 0; j < num_vec + 2; j++) begin
                @(posedge clk);
                if (j < num_vec)
                    drive_line(j);
                else
                    drive_bubble();
                @(negedge clk);
                if (j >= 2) begin
                    check_wb(j - 2);
                end else begin
                    check_value(wb_rf_we_a, 0, "we_a after reset");
                    check_value(wb_rf_we_b, 0, "we_b after reset");
                end
            end
        end
        $display("Checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: test/ex_mem_wb_vectors.txt
# Lane A: valid pc imm rdata1 rdata2 raddr1 raddr2 src1 src2 op we waddr
# Lane B: same twelve, then wb_sel mul_signed | expected: we_a waddr_a wdata_a we_b waddr_b wdata_b
1 00000000 00000000 00000005 00000003 01 02 0 0 0 1 03 1 00000000 00000000 00000010 00000020 04 05 0 0 1 1 06 1 0 1 03 00000008 1 06 fffffff0
1 00000000 00000001 ffffffff 00000000 07 00 0 1 2 1 08 1 00000000 00000001 ffffffff 00000000 09 00 0 1 3 1 0a 1 0 1 08 00000001 1 0a 00000000
1 00000000 00000000 f0f0f0f0 0ff00ff0 0b 0c 0 0 4 1 0d 1 00000000 00000000 12340000 00005678 0e 0f 0 0 5 1 10 1 0 1 0d 00f000f0 1 10 12345678
1 00001000 0000ffff 00000000 00000000 00 00 1 1 6 1 11 1 00000000 00000000 00ff00ff 0f0f0000 12 13 0 0 7 1 14 1 0 1 11 0000efff 1 14 f000ff00
1 00000000 00000024 00000001 00000000 15 00 0 1 8 1 16 1 00000000 0000001f 80000000 00000000 17 00 0 1 9 1 18 1 0 1 16 00000010 1 18 00000001
1 00000000 00000004 80000010 00000000 19 00 0 1 a 1 1a 1 00000000 abcd0000 00000000 00000000 00 00 0 1 b 1 1b 1 0 1 1a f8000001 1 1b abcd0000
1 00002000 fffffffc 00000000 00000000 00 00 1 1 0 1 1c 1 00000000 00000000 ffffffff 00000002 1d 1e 0 0 0 1 1f 2 0 1 1c 00001ffc 1 1f fffffffe
1 00000000 00000000 00000064 00000001 02 01 0 0 1 1 03 1 00000000 00000000 ffffffff 00000002 04 05 0 0 0 1 05 4 0 1 03 00000063 1 05 00000001
0 00000000 00000000 00000000 00000000 00 00 0 0 0 1 0b 1 00000000 00000000 fffffffd 00000007 06 07 0 0 0 1 09 2 1 0 00 00000000 1 09 ffffffeb
1 00000000 00000001 00000100 00000000 0f 00 0 1 5 1 11 1 00000000 00000000 fffffffd 00000007 0c 0d 0 0 0 1 0e 4 1 1 11 00000101 1 0e ffffffff
0 00000000 00000000 00000000 00000000 00 00 0 0 0 1 12 0 00000000 00000000 00000000 00000000 00 00 0 0 0 1 13 1 0 0 00 00000000 0 00 00000000
1 00000000 00000000 00000001 00000002 14 15 0 0 0 1 07 1 00000000 00000000 00000010 00000020 16 17 0 0 0 1 07 1 0 1 07 00000003 1 07 00000030
1 00000000 00000001 0000dead 00000000 07 00 0 1 0 1 18 1 00000000 00000000 0000dead 00000100 07 19 0 0 0 1 1a 1 0 1 18 00000031 1 1a 00000130
1 00000000 00000000 0000dead 00000000 07 00 0 1 5 1 18 1 00000000 00000000 00000000 00000000 18 1a 0 0 0 1 1c 1 0 1 18 00000030 1 1c 00000161
1 00000000 00000000 00000000 00000000 18 00 0 1 0 1 1d 1 00000000 00000000 00000000 00000002 1c 1e 0 0 0 1 1f 2 1 1 1d 00000030 1 1f 000002c2
1 00000000 00000000 00000000 00000000 1f 00 0 1 0 1 01 1 00000000 00000000 00000005 00000006 02 03 0 0 0 1 02 1 0 1 01 000002c2 1 02 0000000b
1 00000000 00000000 00000000 00000000 1f 01 0 0 0 1 03 1 00000000 00000000 00000000 80000000 1f 04 0 0 0 1 04 4 0 1 03 00000584 1 04 00000161
1 00000010 00000005 00000000 00000000 00 00 1 1 0 1 00 1 00000000 00000000 aaaa0000 0000bbbb 05 06 0 0 5 1 00 1 0 1 00 00000015 1 00 aaaabbbb
1 00000000 00000000 00000077 00000000 00 00 0 1 0 1 07 1 00000000 00000000 00000099 00000001 00 00 0 0 1 1 08 1 0 1 07 00000077 1 08 00000098
1 00000000 00000078 00000000 00000000 07 00 0 1 3 1 09 1 00000000 00000004 00000000 00000000 08 00 0 1 9 1 0a 1 0 1 09 00000001 1 0a 00000009

// File: vlog.f
source/exec_pkg.sv
source/operand_forward.sv
source/lane_alu.sv
source/mul_partial.sv
source/wb_select.sv
source/stage_regs.sv
source/ex_mem_wb.sv
test/tb_ex_mem_wb.sv
